/* exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// one word of data path
`define DATA_WIDTH 32

// register file geometry
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// width of the wrapping retire counter
`define RETIRE_WIDTH 16

`endif

/* exec_pkg.sv */
`include "exec_config.svh"

package exec_pkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;
    typedef logic [`RETIRE_WIDTH-1:0] retireCount_t;

    // any unlisted alu op code gives 0
    typedef enum logic [3:0] {
        aluAdd     = 4'h0,
        aluSub     = 4'h1,
        aluAnd     = 4'h2,
        aluOr      = 4'h3,
        aluNor     = 4'h4,
        aluSlt     = 4'h5,
        aluSll     = 4'h6,
        aluSrl     = 4'h7,
        aluXor     = 4'h8,
        aluSll16   = 4'h9,
        aluInvalid = 4'hf
    } aluOp_e;

    typedef enum logic [1:0] {
        stIdle,
        stReadOperands,
        stExecute,
        stWriteBack
    } execState_e;

    typedef struct packed {
        aluOp_e op;
        word_t  leftOperand;
        word_t  rightOperand;
    } aluReq_t;

    // what gets reported on each writeback
    typedef struct packed {
        regAddr_t destReg;
        word_t    data;
        logic     zero;
    } wbInfo_t;

endpackage

/* aluCore.sv */
`timescale 1ns/100ps
`include "exec_config.svh"

module aluCore (
    input  exec_pkg::aluReq_t req,
    output exec_pkg::word_t   result,
    output logic              zero
);
    localparam int shamtWidth = $clog2(`DATA_WIDTH);

    logic                  isSub;
    logic [shamtWidth-1:0] shamt;
    exec_pkg::word_t       addSubResult;
    exec_pkg::word_t       andResult;
    exec_pkg::word_t       orResult;
    exec_pkg::word_t       norResult;
    exec_pkg::word_t       xorResult;
    exec_pkg::word_t       sltResult;
    exec_pkg::word_t       shiftLeftResult;
    exec_pkg::word_t       shiftRightResult;
    exec_pkg::word_t       shiftLeft16Result;

    // one adder serves add, sub and slt
    assign isSub = (req.op == exec_pkg::aluSub) || (req.op == exec_pkg::aluSlt);
    assign addSubResult = req.leftOperand
                        + (isSub ? ~req.rightOperand : req.rightOperand)
                        + {{(`DATA_WIDTH-1){1'b0}}, isSub};

    // sign of the raw difference with overflow ignored
    assign sltResult = {{(`DATA_WIDTH-1){1'b0}}, addSubResult[`DATA_WIDTH-1]};

    assign andResult = req.leftOperand & req.rightOperand;
    assign orResult  = req.leftOperand | req.rightOperand;
    assign norResult = ~(req.leftOperand | req.rightOperand);
    assign xorResult = req.leftOperand ^ req.rightOperand;

    // shift amount rides in the left operand, value in the right
    assign shamt             = req.leftOperand[shamtWidth-1:0];
    assign shiftLeftResult   = req.rightOperand << shamt;
    assign shiftRightResult  = req.rightOperand >> shamt;
    assign shiftLeft16Result = req.rightOperand << 16;

    always_comb begin
        case (req.op)
            exec_pkg::aluAdd:   result = addSubResult;
            exec_pkg::aluSub:   result = addSubResult;
            exec_pkg::aluAnd:   result = andResult;
            exec_pkg::aluOr:    result = orResult;
            exec_pkg::aluNor:   result = norResult;
            exec_pkg::aluSlt:   result = sltResult;
            exec_pkg::aluSll:   result = shiftLeftResult;
            exec_pkg::aluSrl:   result = shiftRightResult;
            exec_pkg::aluXor:   result = xorResult;
            exec_pkg::aluSll16: result = shiftLeft16Result;
            default:            result = '0;
        endcase
    end

    assign zero = ~|result;

endmodule

/* regFile.sv */
`timescale 1ns/100ps
`include "exec_config.svh"

module regFile (
    input  logic               clk,
    input  logic               rstN,
    input  exec_pkg::regAddr_t readAddrA,
    input  exec_pkg::regAddr_t readAddrB,
    output exec_pkg::word_t    readDataA,
    output exec_pkg::word_t    readDataB,
    input  logic               writeEn,
    input  exec_pkg::regAddr_t writeAddr,
    input  exec_pkg::word_t    writeData
);
    exec_pkg::word_t regs [`REG_COUNT];

    // r0 is cleared by reset and never written, so it reads as zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // asynchronous read ports
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

/* execControl.sv */
`timescale 1ns/100ps
`include "exec_config.svh"

module execControl (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  exec_pkg::word_t    instr,
    output logic               busy,
    output exec_pkg::regAddr_t readAddrA,
    output exec_pkg::regAddr_t readAddrB,
    input  exec_pkg::word_t    readDataA,
    input  exec_pkg::word_t    readDataB,
    output exec_pkg::aluReq_t  aluReq,
    input  exec_pkg::word_t    aluResult,
    input  logic               aluZero,
    output logic               writeEn,
    output logic               wbValid,
    output exec_pkg::wbInfo_t  wbInfo
);
    // opcodes
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opSlti  = 6'h0a;
    localparam logic [5:0] opAndi  = 6'h0c;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opXori  = 6'h0e;
    localparam logic [5:0] opLui   = 6'h0f;
    // r-type funct codes
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSllv = 6'h04;
    localparam logic [5:0] fnSrlv = 6'h06;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;

    exec_pkg::execState_e state;
    exec_pkg::word_t      instrReg;
    exec_pkg::aluReq_t    reqNext;
    exec_pkg::regAddr_t   destReg;
    exec_pkg::word_t      signImm;
    exec_pkg::word_t      zeroImm;
    exec_pkg::word_t      shamtExt;
    logic [5:0]           opcode;
    logic [5:0]           funct;

    assign opcode    = instrReg[31:26];
    assign funct     = instrReg[5:0];
    assign readAddrA = instrReg[25:21];
    assign readAddrB = instrReg[20:16];
    assign signImm   = {{(`DATA_WIDTH-16){instrReg[15]}}, instrReg[15:0]};
    assign zeroImm   = {{(`DATA_WIDTH-16){1'b0}}, instrReg[15:0]};
    assign shamtExt  = {{(`DATA_WIDTH-5){1'b0}}, instrReg[10:6]};

    // decode into alu op, operand sources and destination
    always_comb begin
        reqNext.op           = exec_pkg::aluInvalid;
        reqNext.leftOperand  = readDataA;
        reqNext.rightOperand = readDataB;
        destReg              = instrReg[20:16];
        if (opcode == opRType) begin
            destReg = instrReg[15:11];
            case (funct)
                fnAdd:  reqNext.op = exec_pkg::aluAdd;
                fnSub:  reqNext.op = exec_pkg::aluSub;
                fnAnd:  reqNext.op = exec_pkg::aluAnd;
                fnOr:   reqNext.op = exec_pkg::aluOr;
                fnNor:  reqNext.op = exec_pkg::aluNor;
                fnXor:  reqNext.op = exec_pkg::aluXor;
                fnSlt:  reqNext.op = exec_pkg::aluSlt;
                fnSllv: reqNext.op = exec_pkg::aluSll;
                fnSrlv: reqNext.op = exec_pkg::aluSrl;
                fnSll: begin
                    reqNext.op          = exec_pkg::aluSll;
                    reqNext.leftOperand = shamtExt;
                end
                fnSrl: begin
                    reqNext.op          = exec_pkg::aluSrl;
                    reqNext.leftOperand = shamtExt;
                end
                default: reqNext.op = exec_pkg::aluInvalid;
            endcase
        end else begin
            case (opcode)
                opAddi: reqNext.op = exec_pkg::aluAdd;
                opSlti: reqNext.op = exec_pkg::aluSlt;
                opAndi: reqNext.op = exec_pkg::aluAnd;
                opOri:  reqNext.op = exec_pkg::aluOr;
                opXori: reqNext.op = exec_pkg::aluXor;
                opLui:  reqNext.op = exec_pkg::aluSll16;
                default: reqNext.op = exec_pkg::aluInvalid;
            endcase
            // addi and slti sign extend, the rest zero extend
            if (opcode == opAddi || opcode == opSlti) begin
                reqNext.rightOperand = signImm;
            end else begin
                reqNext.rightOperand = zeroImm;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= exec_pkg::stIdle;
        end else begin
            case (state)
                exec_pkg::stIdle: begin
                    if (instrValid) begin
                        state <= exec_pkg::stReadOperands;
                    end
                end
                exec_pkg::stReadOperands: state <= exec_pkg::stExecute;
                exec_pkg::stExecute:      state <= exec_pkg::stWriteBack;
                default:                  state <= exec_pkg::stIdle;
            endcase
        end
    end

    // instruction, alu request and result stage
    always_ff @(posedge clk) begin
        if (state == exec_pkg::stIdle && instrValid) begin
            instrReg <= instr;
        end
        if (state == exec_pkg::stReadOperands) begin
            aluReq <= reqNext;
        end
        if (state == exec_pkg::stExecute) begin
            wbInfo.destReg <= destReg;
            wbInfo.data    <= aluResult;
            wbInfo.zero    <= aluZero;
        end
    end

    assign busy    = (state != exec_pkg::stIdle);
    assign wbValid = (state == exec_pkg::stWriteBack);
    assign writeEn = (state == exec_pkg::stWriteBack);

endmodule

/* retireCounter.sv */
`timescale 1ns/100ps

module retireCounter (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   wbValid,
    output exec_pkg::retireCount_t retireCount
);

    // counts each writeback and wraps at the top
    always_ff @(posedge clk) begin
        if (!rstN) begin
            retireCount <= '0;
        end else if (wbValid) begin
            retireCount <= retireCount + 1'b1;
        end
    end

endmodule

/* execUnit.sv */
`timescale 1ns/100ps

module execUnit (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instrValid,
    input  exec_pkg::word_t        instr,
    output logic                   busy,
    output logic                   wbValid,
    output exec_pkg::wbInfo_t      wbInfo,
    output exec_pkg::retireCount_t retireCount
);
    exec_pkg::regAddr_t readAddrA;
    exec_pkg::regAddr_t readAddrB;
    exec_pkg::word_t    readDataA;
    exec_pkg::word_t    readDataB;
    exec_pkg::aluReq_t  aluReq;
    exec_pkg::word_t    aluResult;
    logic               aluZero;
    logic               writeEn;

    execControl control (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .busy       (busy),
        .readAddrA  (readAddrA),
        .readAddrB  (readAddrB),
        .readDataA  (readDataA),
        .readDataB  (readDataB),
        .aluReq     (aluReq),
        .aluResult  (aluResult),
        .aluZero    (aluZero),
        .writeEn    (writeEn),
        .wbValid    (wbValid),
        .wbInfo     (wbInfo)
    );

    // write port fed straight from the reported writeback
    regFile regs (
        .clk       (clk),
        .rstN      (rstN),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .writeEn   (writeEn),
        .writeAddr (wbInfo.destReg),
        .writeData (wbInfo.data)
    );

    aluCore alu (
        .req    (aluReq),
        .result (aluResult),
        .zero   (aluZero)
    );

    retireCounter retire (
        .clk         (clk),
        .rstN        (rstN),
        .wbValid     (wbValid),
        .retireCount (retireCount)
    );

endmodule

/* execUnit_tb.sv */
`timescale 1ns/100ps

module execUnit_tb;
    logic                   clk;
    logic                   rstN;
    logic                   instrValid;
    exec_pkg::word_t        instr;
    logic                   busy;
    logic                   wbValid;
    exec_pkg::wbInfo_t      wbInfo;
    exec_pkg::retireCount_t retireCount;

    exec_pkg::word_t    vecInstr[$];
    exec_pkg::regAddr_t vecReg[$];
    exec_pkg::word_t    vecData[$];
    logic               vecZero[$];
    logic               loaded;

    execUnit u_dut (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .busy        (busy),
        .wbValid     (wbValid),
        .wbInfo      (wbInfo),
        .retireCount (retireCount)
    );

    always #4 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic checkReg(input string name, input exec_pkg::regAddr_t got,
                            input exec_pkg::regAddr_t exp);
        if (got !== exp) begin
            abortRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkWord(input string name, input exec_pkg::word_t got,
                             input exec_pkg::word_t exp);
        if (got !== exp) begin
            abortRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkCount(input string name, input exec_pkg::retireCount_t got,
                              input exec_pkg::retireCount_t exp);
        if (got !== exp) begin
            abortRun($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // lines starting with # are skipped
    task automatic loadVectors();
        int                 fd;
        int                 fields;
        string              line;
        exec_pkg::word_t    word;
        exec_pkg::regAddr_t dest;
        exec_pkg::word_t    data;
        logic               zero;
        fd = $fopen("exec_vectors.txt", "r");
        if (fd == 0) begin
            abortRun("could not open exec_vectors.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%h %h %h %h", word, dest, data, zero);
                if (line.len() > 0 && line[0] != "#" && fields == 4) begin
                    vecInstr.push_back(word);
                    vecReg.push_back(dest);
                    vecData.push_back(data);
                    vecZero.push_back(zero);
                end
            end
            $fclose(fd);
        end
    endtask

    // four cycles per instruction plus reset and slack
    initial begin
        wait (loaded);
        #((vecInstr.size() * 4 + 20) * 8);
        abortRun("timeout: writeback never arrived");
    end

    initial begin
        int edges;
        clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        loaded     = 1'b0;
        loadVectors();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkBit("busy", busy, 1'b0);
        checkBit("wbValid", wbValid, 1'b0);
        checkCount("retireCount", retireCount, '0);

        for (int i = 0; i < vecInstr.size(); i++) begin
            instr      = vecInstr[i];
            instrValid = 1'b1;
            @(posedge clk);
            edges = 0;
            @(negedge clk);
            instrValid = 1'b0;
            // count edges from accept to the writeback report
            while (!wbValid) begin
                @(posedge clk);
                edges++;
                @(negedge clk);
            end
            if (edges != 2) begin
                abortRun($sformatf("wbValid came %0d cycles after accept, expected 2",
                                   edges));
            end
            checkReg("wbInfo.destReg", wbInfo.destReg, vecReg[i]);
            checkWord("wbInfo.data", wbInfo.data, vecData[i]);
            checkBit("wbInfo.zero", wbInfo.zero, vecZero[i]);
            while (busy) begin
                @(negedge clk);
            end
        end

        checkCount("retireCount", retireCount,
                   exec_pkg::retireCount_t'(vecInstr.size()));
        $display("All checks passed");
        $finish;
    end

endmodule

/* exec_vectors.txt */
# columns: instruction word, expected dest register, expected data, expected zero flag
# all values hex, one instruction per line, run in order
3C011234 01 12340000 0
34215678 01 12345678 0
340200FF 02 000000FF 0
30230F0F 03 00000608 0
384400FF 04 00000000 1
3C058000 05 80000000 0
34060001 06 00000001 0
00223820 07 12345777 0
00E74022 08 00000000 1
00224824 09 00000078 0
00625025 0A 000006FF 0
00025827 0B FFFFFF00 0
002B6026 0C EDCBA978 0
00416822 0D EDCBAA87 0
00A6702A 0E 00000000 1
00C2782A 0F 00000001 0
2970FFFF 10 00000001 0
28317FFF 11 00000000 1
2052FFF0 12 000000EF 0
00019900 13 23456780 0
0005A7C2 14 00000001 0
0001A800 15 12345678 0
00C2B004 16 000001FE 0
0185B806 17 00000080 0
0166C004 18 00000001 0
00220020 00 12345777 0
0000C825 19 00000000 1
0022D03F 1A 00000000 1
8C3B0004 1B 00000000 1

/* files.f */
+incdir+.
exec_pkg.sv
aluCore.sv
regFile.sv
execControl.sv
retireCounter.sv
execUnit.sv
execUnit_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module execUnit_tb -o simv

# the log decides the result, not the exit code
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
